// ==== vlog.f ====
design/accel_pkg.sv
design/fixed_point_alu.sv
design/alu_accel.sv
design/byte_fifo_accel.sv
design/accel_hub.sv
design/accel_subsystem.sv
dv/tb_accel_subsystem.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module tb_accel_subsystem -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_accel_subsystem -f vlog.f
	./obj_dir/Vtb_accel_subsystem

clean:
	rm -rf obj_dir

// ==== dv/tb_accel_subsystem.sv ====
`default_nettype none

module tb_accel_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import accel_pkg::*;

    typedef enum {k_status, k_alu, k_fifo, k_swap_read, k_swap_pulse, k_swap_both, k_side} kind_e;

    typedef struct {
        kind_e               kind;
        logic [id_width-1:0] id;
        accel_rsp_t          exp_rsp;
        alu_op_e             op;
        fixed_t              a;
        fixed_t              b;
        fixed_t              exp_result;
        int                  count;
        int                  exp_count;
        int                  first_byte;
    } entry_t;

    logic       clk = 1'b0;
    logic       rst_n;
    accel_req_t host_req;
    accel_rsp_t host_rsp;
    logic       swap;
    logic [7:0] data;
    logic       data_valid;

    entry_t      tests[$];
    logic [7:0]  stream_bytes[$];
    logic [15:0] lfsr_state = 16'd39;
    int          cycles = 0;
    int          cycle_limit = 0;

    accel_subsystem dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .swap       (swap),
        .data       (data),
        .data_valid (data_valid)
    );

    always #20 clk = ~clk;

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on failure");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            fail_run();
        end
    end

    // feedback polynomial x^16 + x^14 + x^13 + x^11 + 1
    // one step per bit taken
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // add and sub wrap at 16 bits
    // multiply keeps product bits [23:8]
    function automatic fixed_t q88_model(input alu_op_e op, input fixed_t a, input fixed_t b);
        logic signed [2*bus_width-1:0] wide;
        wide = 32'(a) * 32'(b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            default: return wide[frac_bits +: bus_width];
        endcase
    endfunction

    function automatic void add_entry(input kind_e kind, input logic [id_width-1:0] id,
                                      input accel_rsp_t exp_rsp, input alu_op_e op,
                                      input fixed_t a, input fixed_t b, input int count);
        entry_t e;
        e.kind       = kind;
        e.id         = id;
        e.exp_rsp    = exp_rsp;
        e.op         = op;
        e.a          = a;
        e.b          = b;
        e.exp_result = q88_model(op, a, b);
        e.count      = count;
        // bytes past the depth are dropped
        e.exp_count  = (count < fifo_depth) ? count : fifo_depth;
        e.first_byte = stream_bytes.size();
        for (int i = 0; i < count; i++) begin
            stream_bytes.push_back(8'(random_bits(8)));
        end
        tests.push_back(e);
    endfunction

    function automatic void build_tests();
        accel_rsp_t st;
        fixed_t     ra;
        fixed_t     rb;
        for (int id = 0; id < 8; id++) begin
            st           = '0;
            st.can_read  = (id == 0);
            st.can_write = (id == 5);
            add_entry(k_status, id_width'(id), st, op_add, '0, '0, 0);
        end
        st = '0;
        add_entry(k_alu, id_alu, st, op_add, 16'sh0180, 16'sh0280, 0);
        add_entry(k_alu, id_alu, st, op_sub, 16'sh8000, 16'sh0001, 0);
        add_entry(k_alu, id_alu, st, op_mul, 16'sh0180, 16'sh0200, 0);
        add_entry(k_alu, id_alu, st, op_mul, 16'shff00, 16'sh0080, 0);
        for (int i = 0; i < 6; i++) begin
            ra = fixed_t'(random_bits(16));
            rb = fixed_t'(random_bits(16));
            add_entry(k_alu, id_alu, st, alu_op_e'(i % 3), ra, rb, 0);
        end
        add_entry(k_fifo, id_fifo, st, op_add, '0, '0, 5);
        add_entry(k_fifo, id_fifo, st, op_add, '0, '0, 16);
        add_entry(k_fifo, id_fifo, st, op_add, '0, '0, 20);
        add_entry(k_swap_read, id_swap, st, op_add, '0, '0, 0);
        st.can_read = 1'b1;
        add_entry(k_swap_pulse, id_swap, st, op_add, '0, '0, 0);
        add_entry(k_swap_both, id_swap, st, op_add, '0, '0, 0);
        st.can_read = 1'b0;
        add_entry(k_swap_read, id_swap, st, op_add, '0, '0, 0);
        ra = fixed_t'(random_bits(16));
        rb = fixed_t'(random_bits(16));
        add_entry(k_side, id_alu, st, op_mul, ra, rb, 10);
        add_entry(k_side, id_alu, st, op_add, rb, ra, 16);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        fail_run();
    endtask

    task automatic check_fixed(input fixed_t got, input fixed_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    // read data compared only where the bus defines it
    task automatic check_rsp(input accel_rsp_t got, input accel_rsp_t exp, input bit with_data,
                             input string what);
        if (got.can_read !== exp.can_read || got.can_write !== exp.can_write ||
            (with_data && got.read_data !== exp.read_data)) begin
            report_mismatch($sformatf("%s: got %b/%b/%h, expected %b/%b/%h", what,
                got.can_read, got.can_write, got.read_data,
                exp.can_read, exp.can_write, exp.read_data));
        end
    endtask

    task automatic check_byte(input logic [bus_width-1:0] got, input logic [7:0] exp,
                              input string what);
        if (got !== {{(bus_width - 8){1'b0}}, exp}) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic present(input logic [id_width-1:0] id, input logic [bus_width-1:0] wdata);
        @(posedge clk);
        host_req <= '{id: id, read_enable: 1'b0, write_enable: 1'b0, write_data: wdata};
    endtask

    task automatic bus_write(input logic [id_width-1:0] id, input logic [bus_width-1:0] wdata);
        present(id, wdata);
        do @(negedge clk); while (host_rsp.can_write !== 1'b1);
        @(posedge clk);
        host_req.write_enable <= 1'b1;
        @(posedge clk);
        host_req.write_enable <= 1'b0;
    endtask

    task automatic bus_read(input logic [id_width-1:0] id, output logic [bus_width-1:0] value);
        present(id, '0);
        do @(negedge clk); while (host_rsp.can_read !== 1'b1);
        @(posedge clk);
        host_req.read_enable <= 1'b1;
        @(negedge clk);
        value = host_rsp.read_data;
        @(posedge clk);
        host_req.read_enable <= 1'b0;
    endtask

    task automatic alu_operation(input entry_t e);
        logic [bus_width-1:0] value;
        bus_write(id_alu, e.a);
        bus_write(id_alu, e.b);
        bus_write(id_alu, 16'(e.op));
        // busy until the result shows up
        do begin
            @(negedge clk);
            if (host_rsp.can_write !== 1'b0) begin
                report_mismatch("alu can_write high before the result was read");
            end
        end while (host_rsp.can_read !== 1'b1);
        check_rsp(host_rsp, '{can_read: 1'b1, can_write: 1'b0, read_data: e.exp_result},
                  1'b1, "alu ready");
        bus_read(id_alu, value);
        check_fixed(fixed_t'(value), e.exp_result, "alu result");
        @(negedge clk);
        check_rsp(host_rsp, '{can_read: 1'b0, can_write: 1'b1, read_data: '0},
                  1'b0, "alu idle");
    endtask

    task automatic push_bytes(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            data       <= stream_bytes[first + i];
            data_valid <= 1'b1;
        end
        @(posedge clk);
        data_valid <= 1'b0;
    endtask

    task automatic drain_fifo(input entry_t e);
        logic [bus_width-1:0] value;
        for (int i = 0; i < e.exp_count; i++) begin
            bus_read(id_fifo, value);
            check_byte(value, stream_bytes[e.first_byte + i], $sformatf("fifo byte %0d", i));
        end
        @(negedge clk);
        check_rsp(host_rsp, '0, 1'b0, "fifo empty after drain");
    endtask

    task automatic run_entry(input entry_t e);
        logic [bus_width-1:0] value;
        case (e.kind)
            k_status: begin
                present(e.id, '0);
                @(negedge clk);
                // alu and fifo data stay undefined until loaded
                check_rsp(host_rsp, e.exp_rsp, (e.id != id_alu) && (e.id != id_fifo),
                          $sformatf("status of id %0d", e.id));
            end
            k_alu: alu_operation(e);
            k_fifo: begin
                push_bytes(e.first_byte, e.count);
                drain_fifo(e);
            end
            k_swap_read: begin
                bus_read(id_swap, value);
                check_fixed(fixed_t'(value), '0, "swap read data");
                @(negedge clk);
                check_rsp(host_rsp, e.exp_rsp, 1'b1, "swap flag after read");
            end
            k_swap_pulse: begin
                present(id_swap, '0);
                swap <= 1'b1;
                @(posedge clk);
                swap <= 1'b0;
                @(negedge clk);
                check_rsp(host_rsp, e.exp_rsp, 1'b1, "swap flag after pulse");
            end
            k_swap_both: begin
                present(id_swap, '0);
                do @(negedge clk); while (host_rsp.can_read !== 1'b1);
                @(posedge clk);
                host_req.read_enable <= 1'b1;
                swap                 <= 1'b1;
                @(posedge clk);
                host_req.read_enable <= 1'b0;
                swap                 <= 1'b0;
                @(negedge clk);
                check_rsp(host_rsp, e.exp_rsp, 1'b1, "swap flag after swap with read");
            end
            default: begin
                // stream runs while the alu op is in flight
                fork
                    alu_operation(e);
                    push_bytes(e.first_byte, e.count);
                join
                drain_fifo(e);
            end
        endcase
    endtask

    initial begin
        rst_n      = 1'b0;
        host_req   = '0;
        swap       = 1'b0;
        data       = '0;
        data_valid = 1'b0;
        build_tests();
        cycle_limit = tests.size() * 64 + 200;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/accel_subsystem.sv ====
`default_nettype none

module accel_subsystem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  accel_pkg::accel_req_t host_req,
    output accel_pkg::accel_rsp_t host_rsp,
    input  logic                 swap,
    input  logic [7:0]           data,
    input  logic                 data_valid
);
    import accel_pkg::*;

    port_req_t alu_req;
    port_rsp_t alu_rsp;
    port_req_t fifo_req;
    port_rsp_t fifo_rsp;

    logic    alu_start;
    logic    alu_done;
    alu_op_e alu_op;
    fixed_t  alu_a;
    fixed_t  alu_b;
    fixed_t  alu_result;

    accel_hub hub_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .swap     (swap),
        .alu_req  (alu_req),
        .alu_rsp  (alu_rsp),
        .fifo_req (fifo_req),
        .fifo_rsp (fifo_rsp)
    );

    // id 5
    alu_accel alu_accel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_req (alu_req),
        .port_rsp (alu_rsp),
        .start    (alu_start),
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .done     (alu_done),
        .result   (alu_result)
    );

    fixed_point_alu alu_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (alu_start),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .done   (alu_done),
        .result (alu_result)
    );

    // id 7
    byte_fifo_accel fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .data       (data),
        .data_valid (data_valid),
        .port_req   (fifo_req),
        .port_rsp   (fifo_rsp)
    );

endmodule

`default_nettype wire

// ==== design/accel_hub.sv ====
`default_nettype none

module accel_hub (
    input  logic                 clk,
    input  logic                 rst_n,
    input  accel_pkg::accel_req_t host_req,
    output accel_pkg::accel_rsp_t host_rsp,
    input  logic                 swap,
    output accel_pkg::port_req_t  alu_req,
    input  accel_pkg::port_rsp_t  alu_rsp,
    output accel_pkg::port_req_t  fifo_req,
    input  accel_pkg::port_rsp_t  fifo_rsp
);
    import accel_pkg::*;

    logic sel_swap;
    logic sel_alu;
    logic sel_fifo;
    logic swap_read;
    logic swap_pending;

    assign sel_swap = (host_req.id == id_swap);
    assign sel_alu  = (host_req.id == id_alu);
    assign sel_fifo = (host_req.id == id_fifo);

    // enables reach only the addressed target
    assign alu_req.read_enable   = sel_alu && host_req.read_enable;
    assign alu_req.write_enable  = sel_alu && host_req.write_enable;
    assign alu_req.write_data    = host_req.write_data;

    assign fifo_req.read_enable  = sel_fifo && host_req.read_enable;
    assign fifo_req.write_enable = sel_fifo && host_req.write_enable;
    assign fifo_req.write_data   = host_req.write_data;

    assign swap_read = sel_swap && host_req.read_enable;

    // status and read data merge, unknown ids stay zero
    always_comb begin
        host_rsp = '0;
        case (host_req.id)
            id_swap: host_rsp.can_read = swap_pending;
            id_alu: begin
                host_rsp.can_read  = alu_rsp.can_read;
                host_rsp.can_write = alu_rsp.can_write;
                host_rsp.read_data = alu_rsp.read_data;
            end
            id_fifo: begin
                host_rsp.can_read  = fifo_rsp.can_read;
                host_rsp.can_write = fifo_rsp.can_write;
                host_rsp.read_data = fifo_rsp.read_data;
            end
            default: ;
        endcase
    end

    // starts set so the first frame can be taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            swap_pending <= 1'b1;
        end else if (swap) begin
            swap_pending <= 1'b1;
        end else if (swap_read) begin
            swap_pending <= 1'b0;
        end
    end

    read_only_when_allowed: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_req.read_enable |-> host_rsp.can_read
    );

    write_only_when_allowed: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_req.write_enable |-> host_rsp.can_write
    );

endmodule

`default_nettype wire

// ==== design/byte_fifo_accel.sv ====
`default_nettype none

module byte_fifo_accel (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          data,
    input  logic                data_valid,
    input  accel_pkg::port_req_t port_req,
    output accel_pkg::port_rsp_t port_rsp
);
    import accel_pkg::*;

    logic [7:0] mem [fifo_depth];

    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width:0]   count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == (fifo_ptr_width + 1)'(fifo_depth));
    assign empty = (count == '0);

    // stream bytes dropped while full
    assign push = data_valid && !full;
    assign pop  = port_req.read_enable && !empty;

    // pointers wrap at the power of two depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    assign port_rsp.can_read  = !empty;
    assign port_rsp.can_write = 1'b0;
    assign port_rsp.read_data = {{(bus_width - 8){1'b0}}, mem[rd_ptr]};

    count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= (fifo_ptr_width + 1)'(fifo_depth)
    );

endmodule

`default_nettype wire

// ==== design/alu_accel.sv ====
`default_nettype none

module alu_accel (
    input  logic                clk,
    input  logic                rst_n,
    input  accel_pkg::port_req_t port_req,
    output accel_pkg::port_rsp_t port_rsp,
    output logic                start,
    output accel_pkg::alu_op_e   op,
    output accel_pkg::fixed_t    a,
    output accel_pkg::fixed_t    b,
    input  logic                done,
    input  accel_pkg::fixed_t    result
);
    import accel_pkg::*;

    typedef enum logic [2:0] {
        st_a,
        st_b,
        st_op,
        st_busy,
        st_ready
    } state_e;

    state_e state;
    fixed_t held_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_a;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                st_a:     if (port_req.write_enable) state <= st_b;
                st_b:     if (port_req.write_enable) state <= st_op;
                st_op: begin
                    if (port_req.write_enable) begin
                        state <= st_busy;
                        start <= 1'b1;
                    end
                end
                st_busy:  if (done) state <= st_ready;
                st_ready: if (port_req.read_enable) state <= st_a;
                default:  state <= st_a;
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (port_req.write_enable) begin
            case (state)
                st_a:    a <= port_req.write_data;
                st_b:    b <= port_req.write_data;
                st_op:   op <= alu_op_e'(port_req.write_data[1:0]);
                default: ;
            endcase
        end
        if (state == st_busy && done) begin
            held_result <= result;
        end
    end

    assign port_rsp.can_read  = (state == st_ready);
    assign port_rsp.can_write = (state == st_a) || (state == st_b) || (state == st_op);
    assign port_rsp.read_data = held_result;

    done_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> state == st_busy
    );

endmodule

`default_nettype wire

// ==== design/fixed_point_alu.sv ====
`default_nettype none

module fixed_point_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  accel_pkg::alu_op_e op,
    input  accel_pkg::fixed_t  a,
    input  accel_pkg::fixed_t  b,
    output logic              done,
    output accel_pkg::fixed_t  result
);
    import accel_pkg::*;

    logic    s1_valid;
    alu_op_e s1_op;
    fixed_t  s1_a;
    fixed_t  s1_b;

    logic signed [2*bus_width-1:0] product;
    fixed_t                        shifted;
    fixed_t                        s2_value;

    // stage one valid and done pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (start) begin
            s1_op <= op;
            s1_a  <= a;
            s1_b  <= b;
        end
    end

    // full precision product with the extra fraction dropped
    always_comb begin
        product = s1_a * s1_b;
        shifted = fixed_t'(product >>> frac_bits);
        case (s1_op)
            op_add:  s2_value = s1_a + s1_b;
            op_sub:  s2_value = s1_a - s1_b;
            op_mul:  s2_value = shifted;
            default: s2_value = s1_a + s1_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result <= s2_value;
        end
    end

    done_two_after_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> ##2 done
    );

endmodule

`default_nettype wire

// ==== design/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

    localparam int bus_width      = 16;
    localparam int id_width       = 4;
    localparam int frac_bits      = 8;
    localparam int fifo_depth     = 16;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    // accelerator ids on the host bus
    localparam logic [id_width-1:0] id_swap = 4'd0;
    localparam logic [id_width-1:0] id_alu  = 4'd5;
    localparam logic [id_width-1:0] id_fifo = 4'd7;

    // signed Q8.8
    typedef logic signed [bus_width-1:0] fixed_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } alu_op_e;

    typedef struct packed {
        logic [id_width-1:0]  id;
        logic                 read_enable;
        logic                 write_enable;
        logic [bus_width-1:0] write_data;
    } accel_req_t;

    typedef struct packed {
        logic                 can_read;
        logic                 can_write;
        logic [bus_width-1:0] read_data;
    } accel_rsp_t;

    // per target, id already decoded by the hub
    typedef struct packed {
        logic                 read_enable;
        logic                 write_enable;
        logic [bus_width-1:0] write_data;
    } port_req_t;

    typedef struct packed {
        logic                 can_read;
        logic                 can_write;
        logic [bus_width-1:0] read_data;
    } port_rsp_t;

endpackage

`default_nettype wire
